//--- source/rv_isa_pkg.sv
// ============================================================
// RV32I architectural constants
// ============================================================
package rv_isa_pkg;

  // Data path width and register file geometry
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 2 ** reg_addr_w;  // x0 .. x31

  typedef logic [31:0]           instr_t;     // Always 32-bit, no compressed
  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // ============================================================
  // Major opcodes, instr[6:0]
  // ============================================================
  localparam logic [6:0] opcode_op     = 7'b0110011;  // R-type ALU
  localparam logic [6:0] opcode_op_imm = 7'b0010011;  // I-type ALU
  localparam logic [6:0] opcode_lui    = 7'b0110111;  // U-type

  // ============================================================
  // funct3, instr[14:12]
  // ============================================================
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct7, instr[31:25]
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;  // SUB, SRA, SRAI

endpackage

//--- source/rv_pipe_pkg.sv
// ============================================================
// Pipeline payloads passed between stages
// ============================================================
package rv_pipe_pkg;

  // ALU operation select
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // LUI, operand B straight through
  } alu_op_t;

  // Decode stage output, captured in ID/EX
  typedef struct packed {
    logic                  valid;
    logic                  illegal;    // Unsupported encoding
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    logic                  uses_rs1;   // Low for LUI
    logic                  use_imm;    // Operand B from imm
    rv_isa_pkg::word_t     imm;
    alu_op_t               alu_op;
    logic                  reg_write;  // Legal and rd != x0
  } decoded_t;

  // Execute result, carried through EX/MEM and MEM/WB
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    rv_isa_pkg::reg_addr_t rd;
    logic                  reg_write;
    rv_isa_pkg::word_t     data;       // Zero for illegal
  } result_t;

endpackage

//--- source/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  instr_valid,
  input  rv_isa_pkg::instr_t    instr,
  output rv_pipe_pkg::decoded_t decoded
);

  // ============================================================
  // IF/ID register
  // ============================================================
  rv_isa_pkg::instr_t instr_q;
  logic               valid_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      instr_q <= '0;
      valid_q <= 1'b0;
    end else begin
      instr_q <= instr;        // Sampled every cycle, qualified by valid_q
      valid_q <= instr_valid;
    end
  end

  // Field slices
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::reg_addr_t rs2;
  rv_isa_pkg::word_t     imm_i;
  rv_isa_pkg::word_t     imm_u;

  assign opcode = instr_q[6:0];
  assign rd     = instr_q[11:7];
  assign funct3 = instr_q[14:12];
  assign rs1    = instr_q[19:15];
  assign rs2    = instr_q[24:20];
  assign funct7 = instr_q[31:25];

  assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};  // Sign-extended
  assign imm_u = {instr_q[31:12], 12'b0};              // Upper 20 bits

  // funct3 to ALU op, alt selects SUB or SRA
  function automatic rv_pipe_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      rv_isa_pkg::f3_add_sub: return alt ? rv_pipe_pkg::alu_sub : rv_pipe_pkg::alu_add;
      rv_isa_pkg::f3_sll:     return rv_pipe_pkg::alu_sll;
      rv_isa_pkg::f3_slt:     return rv_pipe_pkg::alu_slt;
      rv_isa_pkg::f3_sltu:    return rv_pipe_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:     return rv_pipe_pkg::alu_xor;
      rv_isa_pkg::f3_srl_sra: return alt ? rv_pipe_pkg::alu_sra : rv_pipe_pkg::alu_srl;
      rv_isa_pkg::f3_or:      return rv_pipe_pkg::alu_or;
      default:                return rv_pipe_pkg::alu_and;
    endcase
  endfunction

  // ============================================================
  // Control decode and illegal detection
  // ============================================================
  logic                 legal;
  logic                 use_imm;
  logic                 uses_rs1;
  logic                 f7_is_base;
  logic                 f7_is_alt;
  rv_isa_pkg::word_t    imm_sel;
  rv_pipe_pkg::alu_op_t op_sel;

  assign f7_is_base = (funct7 == rv_isa_pkg::f7_base);
  assign f7_is_alt  = (funct7 == rv_isa_pkg::f7_alt);

  always_comb begin
    legal    = 1'b0;
    use_imm  = 1'b0;
    uses_rs1 = 1'b1;
    imm_sel  = imm_i;
    op_sel   = rv_pipe_pkg::alu_add;
    case (opcode)
      rv_isa_pkg::opcode_op: begin
        // Alt code only for SUB and SRA
        legal  = f7_is_base || (f7_is_alt && (funct3 == rv_isa_pkg::f3_add_sub ||
                                              funct3 == rv_isa_pkg::f3_srl_sra));
        op_sel = arith_op(funct3, funct7[5]);
      end
      rv_isa_pkg::opcode_op_imm: begin
        use_imm = 1'b1;
        case (funct3)
          rv_isa_pkg::f3_sll:     legal = f7_is_base;               // SLLI
          rv_isa_pkg::f3_srl_sra: legal = f7_is_base || f7_is_alt;  // SRLI / SRAI
          default:                legal = 1'b1;
        endcase
        // No SUBI, bit 30 of an ADDI immediate is just data
        op_sel = arith_op(funct3, funct7[5] && (funct3 == rv_isa_pkg::f3_srl_sra));
      end
      rv_isa_pkg::opcode_lui: begin
        legal    = 1'b1;
        use_imm  = 1'b1;
        uses_rs1 = 1'b0;   // rs1 field is immediate bits
        imm_sel  = imm_u;
        op_sel   = rv_pipe_pkg::alu_pass_b;
      end
      default: legal = 1'b0;  // Everything else unsupported
    endcase
  end

  // Decoded payload toward execute
  always_comb begin
    decoded.valid     = valid_q;
    decoded.illegal   = valid_q && !legal;
    decoded.rd        = rd;
    decoded.rs1       = rs1;
    decoded.rs2       = rs2;
    decoded.uses_rs1  = uses_rs1;
    decoded.use_imm   = use_imm;
    decoded.imm       = imm_sel;
    decoded.alu_op    = op_sel;
    decoded.reg_write = valid_q && legal && (rd != '0);  // x0 writes dropped here
  end

endmodule

//--- source/rv_register_file.sv
`timescale 1ns/10ps

module rv_register_file (
  input  logic                  clk,
  input  logic                  reset_n,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data,
  input  rv_pipe_pkg::result_t  write
);

  // ============================================================
  // Storage, x1 .. x31 (x0 hardwired)
  // ============================================================
  rv_isa_pkg::word_t regs [1:rv_isa_pkg::num_regs-1];

  logic write_en;

  assign write_en = write.valid && write.reg_write && (write.rd != '0);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < rv_isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[write.rd] <= write.data;
    end
  end

  // Read port with same-cycle writeback bypass
  function automatic rv_isa_pkg::word_t read_port(
    input rv_isa_pkg::reg_addr_t addr,
    input rv_isa_pkg::word_t     stored
  );
    if (addr == '0) begin
      return '0;                 // x0 reads zero
    end else if (write_en && (write.rd == addr)) begin
      return write.data;         // Bypass, storage updates next edge
    end else begin
      return stored;
    end
  endfunction

  // Index 0 is outside the array, guarded inside read_port
  rv_isa_pkg::word_t rs1_stored;
  rv_isa_pkg::word_t rs2_stored;

  assign rs1_stored = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_stored = (rs2 == '0) ? '0 : regs[rs2];

  assign rs1_data = read_port(rs1, rs1_stored);
  assign rs2_data = read_port(rs2, rs2_stored);

endmodule

//--- source/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
  input  logic                  clk,
  input  logic                  reset_n,
  input  rv_pipe_pkg::decoded_t decoded,
  input  rv_isa_pkg::word_t     rs1_data,
  input  rv_isa_pkg::word_t     rs2_data,
  input  rv_pipe_pkg::result_t  wb_result,  // MEM/WB, for forwarding
  output rv_pipe_pkg::result_t  ex_result   // EX/MEM register
);

  // ============================================================
  // ID/EX register
  // ============================================================
  rv_pipe_pkg::decoded_t idex_q;
  rv_isa_pkg::word_t     rs1_q;
  rv_isa_pkg::word_t     rs2_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idex_q <= '0;
      rs1_q  <= '0;
      rs2_q  <= '0;
    end else begin
      idex_q <= decoded;
      rs1_q  <= rs1_data;
      rs2_q  <= rs2_data;
    end
  end

  // ============================================================
  // Operand forwarding
  // ============================================================

  // Does a younger result write this source register
  function automatic logic result_hits(
    input rv_pipe_pkg::result_t  res,
    input rv_isa_pkg::reg_addr_t src
  );
    return res.valid && res.reg_write && (res.rd == src) && (src != '0);
  endfunction

  // EX/MEM first, then MEM/WB, then ID/EX copy
  function automatic rv_isa_pkg::word_t forward(
    input rv_isa_pkg::reg_addr_t src,
    input rv_isa_pkg::word_t     reg_val,
    input rv_pipe_pkg::result_t  exm,
    input rv_pipe_pkg::result_t  wb
  );
    if (result_hits(exm, src)) begin
      return exm.data;    // Distance 1
    end else if (result_hits(wb, src)) begin
      return wb.data;     // Distance 2
    end else begin
      return reg_val;     // Distance 3 came through the regfile bypass
    end
  endfunction

  rv_isa_pkg::word_t rs1_fwd;
  rv_isa_pkg::word_t rs2_fwd;
  rv_isa_pkg::word_t op_a;
  rv_isa_pkg::word_t op_b;
  logic [4:0]        shamt;

  assign rs1_fwd = forward(idex_q.rs1, rs1_q, ex_result, wb_result);
  assign rs2_fwd = forward(idex_q.rs2, rs2_q, ex_result, wb_result);

  // LUI rs1 field is immediate bits, never forward it
  assign op_a  = idex_q.uses_rs1 ? rs1_fwd : rs1_q;
  assign op_b  = idex_q.use_imm ? idex_q.imm : rs2_fwd;
  assign shamt = op_b[4:0];  // RV32 shift amount

  // ============================================================
  // ALU
  // ============================================================
  rv_isa_pkg::word_t alu_out;
  logic              lt_signed;
  logic              lt_unsigned;

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  always_comb begin
    case (idex_q.alu_op)
      rv_pipe_pkg::alu_add:    alu_out = op_a + op_b;
      rv_pipe_pkg::alu_sub:    alu_out = op_a - op_b;
      rv_pipe_pkg::alu_sll:    alu_out = op_a << shamt;
      rv_pipe_pkg::alu_slt:    alu_out = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_signed};
      rv_pipe_pkg::alu_sltu:   alu_out = {{(rv_isa_pkg::xlen-1){1'b0}}, lt_unsigned};
      rv_pipe_pkg::alu_xor:    alu_out = op_a ^ op_b;
      rv_pipe_pkg::alu_srl:    alu_out = op_a >> shamt;
      rv_pipe_pkg::alu_sra:    alu_out = rv_isa_pkg::word_t'($signed(op_a) >>> shamt);
      rv_pipe_pkg::alu_or:     alu_out = op_a | op_b;
      rv_pipe_pkg::alu_and:    alu_out = op_a & op_b;
      rv_pipe_pkg::alu_pass_b: alu_out = op_b;
      default:                 alu_out = '0;
    endcase
  end

  // ============================================================
  // EX/MEM register
  // ============================================================
  rv_pipe_pkg::result_t result_next;

  always_comb begin
    result_next.valid     = idex_q.valid;
    result_next.illegal   = idex_q.illegal;
    result_next.rd        = idex_q.rd;
    result_next.reg_write = idex_q.reg_write;
    // Illegal and bubbles carry zero data
    result_next.data      = (idex_q.valid && !idex_q.illegal) ? alu_out : '0;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ex_result <= '0;
    end else begin
      ex_result <= result_next;
    end
  end

endmodule

//--- source/rv_retire.sv
`timescale 1ns/10ps

module rv_retire (
  input  logic                  clk,
  input  logic                  reset_n,
  input  rv_pipe_pkg::result_t  ex_result,
  output rv_pipe_pkg::result_t  wb_result,
  output logic                  retire_valid,
  output logic                  retire_we,
  output logic                  retire_illegal,
  output rv_isa_pkg::reg_addr_t retire_rd,
  output rv_isa_pkg::word_t     retire_data
);

  // ============================================================
  // MEM/WB register
  // ============================================================
  rv_pipe_pkg::result_t memwb_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      memwb_q <= '0;
    end else begin
      memwb_q <= ex_result;  // Memory slot adds no work
    end
  end

  // Feeds EX forwarding and the regfile write port
  assign wb_result = memwb_q;

  // Retire report
  assign retire_valid   = memwb_q.valid;
  assign retire_we      = memwb_q.reg_write;  // Already qualified in decode
  assign retire_illegal = memwb_q.illegal;
  assign retire_rd      = memwb_q.rd;
  assign retire_data    = memwb_q.data;

endmodule

//--- source/rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  instr_valid,
  input  rv_isa_pkg::instr_t    instr,
  output logic                  retire_valid,
  output logic                  retire_we,
  output logic                  retire_illegal,
  output rv_isa_pkg::reg_addr_t retire_rd,
  output rv_isa_pkg::word_t     retire_data
);

  // ============================================================
  // Stage to stage wires
  // ============================================================
  rv_pipe_pkg::decoded_t decoded;     // ID out
  rv_isa_pkg::word_t     rs1_data;
  rv_isa_pkg::word_t     rs2_data;
  rv_pipe_pkg::result_t  ex_result;   // EX/MEM
  rv_pipe_pkg::result_t  wb_result;   // MEM/WB

  // Decode, IF/ID inside
  rv_decoder decoder_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .decoded     (decoded)
  );

  // Regfile read beside the decoder, written from MEM/WB
  rv_register_file register_file_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .rs1      (decoded.rs1),
    .rs2      (decoded.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .write    (wb_result)
  );

  rv_execute execute_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .decoded   (decoded),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .wb_result (wb_result),
    .ex_result (ex_result)
  );

  rv_retire retire_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .ex_result      (ex_result),
    .wb_result      (wb_result),
    .retire_valid   (retire_valid),
    .retire_we      (retire_we),
    .retire_illegal (retire_illegal),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data)
  );

endmodule

//--- tests/tb_rv_core_assertions.sv
`timescale 1ns/10ps

module tb_rv_core_assertions (
  input logic                  clk,
  input logic                  reset_n,
  input logic                  retire_valid,
  input logic                  retire_we,
  input logic                  retire_illegal,
  input rv_isa_pkg::reg_addr_t retire_rd
);

  // ============================================================
  // Retire port rules
  // ============================================================
  we_needs_valid: assert property (@(posedge clk) disable iff (!reset_n)
    retire_we |-> retire_valid)
    else $error("retire_we high without retire_valid");

  illegal_needs_valid: assert property (@(posedge clk) disable iff (!reset_n)
    retire_illegal |-> retire_valid)
    else $error("retire_illegal high without retire_valid");

  // x0 writes are never reported
  we_not_x0: assert property (@(posedge clk) disable iff (!reset_n)
    retire_we |-> (retire_rd != '0))
    else $error("retire_we high with retire_rd zero");

  illegal_no_write: assert property (@(posedge clk) disable iff (!reset_n)
    retire_illegal |-> !retire_we)
    else $error("retire_illegal and retire_we both high");

  // Pipeline empty in reset and while the first instruction travels
  quiet_in_reset: assert property (@(posedge clk) !reset_n |-> !retire_valid)
    else $error("retire_valid high during reset");

  quiet_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !retire_valid [*4])
    else $error("retire_valid high within 4 cycles of reset release");

endmodule

bind rv_core tb_rv_core_assertions core_checks_i (
  .clk            (clk),
  .reset_n        (reset_n),
  .retire_valid   (retire_valid),
  .retire_we      (retire_we),
  .retire_illegal (retire_illegal),
  .retire_rd      (retire_rd)
);

//--- tests/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

  localparam int unsigned seed        = 32'h7b86555a;
  localparam int          num_instr   = 400;
  localparam int          max_cycles  = 2000;  // Issue loop bound
  localparam int          drain_limit = 40;
  localparam int          latency     = 4;     // Issue cycle to retire cycle

  // One expected retire, in issue order
  typedef struct packed {
    logic [31:0]           cycle;    // Cycle the strobe was driven
    rv_isa_pkg::reg_addr_t rd;
    logic                  we;
    logic                  illegal;
    rv_isa_pkg::word_t     data;
  } expect_t;

  logic                  clk = 1'b0;
  logic                  reset_n;
  logic                  instr_valid;
  rv_isa_pkg::instr_t    instr;
  logic                  retire_valid;
  logic                  retire_we;
  logic                  retire_illegal;
  rv_isa_pkg::reg_addr_t retire_rd;
  rv_isa_pkg::word_t     retire_data;

  rv_isa_pkg::word_t arch [0:31];  // Architectural model state
  expect_t           expect_q [$];
  int                cycle  = 0;
  int                errors = 0;
  int                checks = 0;

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) cycle <= cycle + 1;

  rv_core rv_core_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .retire_valid   (retire_valid),
    .retire_we      (retire_we),
    .retire_illegal (retire_illegal),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data)
  );

  // ============================================================
  // Stimulus
  // ============================================================

  // Mostly x0..x7 for tight dependencies
  function automatic rv_isa_pkg::reg_addr_t pick_reg();
    return ($urandom_range(0, 7) != 0) ? 5'($urandom_range(0, 7)) : 5'($urandom_range(0, 31));
  endfunction

  function automatic rv_isa_pkg::instr_t random_instr();
    int unsigned           pick;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    logic [2:0]            f3;
    logic [6:0]            f7;
    logic [31:0]           bits;
    pick = $urandom_range(0, 99);
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    f3   = 3'($urandom_range(0, 7));
    bits = $urandom();
    f7   = rv_isa_pkg::f7_base;
    if ((f3 == rv_isa_pkg::f3_add_sub || f3 == rv_isa_pkg::f3_srl_sra) && bits[31]) begin
      f7 = rv_isa_pkg::f7_alt;   // SUB, SRA, SRAI
    end
    if (pick < 45) begin
      return {f7, rs2, rs1, f3, rd, rv_isa_pkg::opcode_op};
    end else if (pick < 85) begin
      if (f3 == rv_isa_pkg::f3_sll || f3 == rv_isa_pkg::f3_srl_sra) begin
        return {f7, bits[4:0], rs1, f3, rd, rv_isa_pkg::opcode_op_imm};  // Shift immediate
      end
      return {bits[11:0], rs1, f3, rd, rv_isa_pkg::opcode_op_imm};
    end else if (pick < 95) begin
      return {bits[19:0], rd, rv_isa_pkg::opcode_lui};
    end else if (pick < 98) begin
      return {7'b0000001, rs2, rs1, f3, rd, rv_isa_pkg::opcode_op};  // M extension code
    end
    return {bits[31:7], 7'b1100011};  // Branch opcode, unsupported
  endfunction

  // Reference model straight from the RV32I rules
  task automatic model_issue(input rv_isa_pkg::instr_t ins, input int cyc);
    logic [6:0]        opc;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic              ok;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t res;
    expect_t           e;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    a   = arch[ins[19:15]];
    b   = (opc == rv_isa_pkg::opcode_op) ? arch[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    ok  = 1'b1;
    case (f3)
      3'd0: res = (opc == rv_isa_pkg::opcode_op && f7[5]) ? a - b : a + b;
      3'd1: res = a << b[4:0];
      3'd2: res = {31'b0, $signed(a) < $signed(b)};
      3'd3: res = {31'b0, a < b};
      3'd4: res = a ^ b;
      3'd5: begin
        if (f7[5]) begin
          res = $signed(a) >>> b[4:0];  // SRA, SRAI
        end else begin
          res = a >> b[4:0];
        end
      end
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    if (opc == rv_isa_pkg::opcode_op) begin
      ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
    end else if (opc == rv_isa_pkg::opcode_op_imm) begin
      if (f3 == 3'd1) ok = (f7 == 7'h00);
      else if (f3 == 3'd5) ok = (f7 == 7'h00 || f7 == 7'h20);
    end else if (opc == rv_isa_pkg::opcode_lui) begin
      res = {ins[31:12], 12'b0};
    end else begin
      ok = 1'b0;
    end
    e.cycle   = cyc;
    e.rd      = ins[11:7];
    e.illegal = !ok;
    e.we      = ok && (ins[11:7] != 5'd0);
    e.data    = ok ? res : '0;
    if (e.we) arch[e.rd] = res;  // x0 never written
    expect_q.push_back(e);
  endtask

  // ============================================================
  // Retire monitor, sampled mid-cycle
  // ============================================================
  task automatic check_retire();
    expect_t e;
    if (expect_q.size() == 0) begin
      errors++;
      $display("Retire seen at cycle %0d with no instruction outstanding", cycle);
      return;
    end
    e = expect_q.pop_front();
    checks++;
    if (cycle != e.cycle + latency) begin
      errors++;
      $display("FAIL retire cycle: expected %h, got %h", e.cycle + latency, cycle);
    end
    if (retire_rd != e.rd) begin
      errors++;
      $display("FAIL retire_rd: expected %h, got %h", e.rd, retire_rd);
    end
    if (retire_we != e.we) begin
      errors++;
      $display("FAIL retire_we: expected %h, got %h", e.we, retire_we);
    end
    if (retire_illegal != e.illegal) begin
      errors++;
      $display("FAIL retire_illegal: expected %h, got %h", e.illegal, retire_illegal);
    end
    if (retire_data != e.data) begin
      errors++;
      $display("FAIL retire_data: expected %h, got %h", e.data, retire_data);
    end
  endtask

  always @(negedge clk) begin
    if (retire_valid) check_retire();
  end

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    int issued;
    int waited;
    void'($urandom(seed));
    for (int i = 0; i < 32; i++) arch[i] = '0;
    issued      = 0;
    waited      = 0;
    reset_n     = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    repeat (8) @(posedge clk);
    #1 reset_n = 1'b1;
    repeat (3) @(posedge clk);  // Idle, retire must stay low
    while (issued < num_instr && waited < max_cycles) begin
      @(posedge clk);
      #1;
      waited++;
      if ($urandom_range(0, 3) != 0) begin
        instr       = random_instr();
        instr_valid = 1'b1;
        model_issue(instr, cycle);
        issued++;
      end else begin
        instr_valid = 1'b0;
        instr       = $urandom();  // Junk, must be ignored
      end
    end
    if (issued < num_instr) begin
      errors++;
      $display("Issue loop ran out of cycles after %0d instructions", issued);
    end
    @(posedge clk);
    #1 instr_valid = 1'b0;
    waited = 0;
    while (expect_q.size() != 0 && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end
    if (expect_q.size() != 0) begin
      errors++;
      $display("Timeout: %0d instructions never retired", expect_q.size());
    end
    repeat (6) @(posedge clk);  // Catch stray retires
    $display("Retire checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/rv_decoder.sv
source/rv_register_file.sv
source/rv_execute.sv
source/rv_retire.sv
source/rv_core.sv
tests/tb_rv_core_assertions.sv
tests/tb_rv_core.sv
